// ==== hw/hand_if.sv ====
`default_nettype none

interface hand_if
    import uno_card_pkg::*;
();

    logic        add_valid;
    card_t       add_card;
    logic        remove_valid;
    card_t       remove_card;      // wilds keep their wild value code
    value_t      query_value;

    color_mask_t color_present;    // colours with any coloured card
    color_mask_t value_colors;     // colours holding query_value
    logic        wild_present;
    logic        wild4_present;

    modport player (
        output add_valid, add_card, remove_valid, remove_card, query_value,
        input  color_present, value_colors, wild_present, wild4_present
    );

    modport store (
        input  add_valid, add_card, remove_valid, remove_card, query_value,
        output color_present, value_colors, wild_present, wild4_present
    );

endinterface

`default_nettype wire

// ==== hw/hand_store.sv ====
`default_nettype none

`include "uno_macros.svh"

module hand_store
    import uno_card_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    hand_if.store      hand,
    output hand_num_t  o_hand_num,
    output score_t     o_score
);

    count_t      color_cnt [4][`UNO_NUM_VALUES];
    count_t      wild_cnt;
    count_t      wild4_cnt;
    hand_num_t   hand_num_r;
    score_t      score_r;

    color_t      add_color;
    value_t      add_value;
    color_t      rem_color;
    value_t      rem_value;

    color_mask_t color_present;
    color_mask_t value_colors;

    function automatic score_t card_score(input value_t v);
        score_t s;
        if (v == value_t'(`UNO_WILD) || v == value_t'(`UNO_WILD4)) begin
            s = score_t'(`UNO_WILD_SCORE);
        end else if (v >= value_t'(10)) begin
            s = score_t'(`UNO_ACTION_SCORE);
        end else begin
            s = score_t'(v);
        end
        return s;
    endfunction

    assign {add_color, add_value} = hand.add_card;
    assign {rem_color, rem_value} = hand.remove_card;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int c = 0; c < 4; c++) begin
                for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
                    color_cnt[c][v] <= '0;
                end
            end
            wild_cnt   <= '0;
            wild4_cnt  <= '0;
            hand_num_r <= '0;
            score_r    <= '0;
        end else if (hand.add_valid) begin
            hand_num_r <= hand_num_r + 1'b1;
            score_r    <= score_r + card_score(add_value);
            if (add_value == value_t'(`UNO_WILD)) begin
                wild_cnt <= wild_cnt + 1'b1;
            end else if (add_value == value_t'(`UNO_WILD4)) begin
                wild4_cnt <= wild4_cnt + 1'b1;
            end else if (add_value < value_t'(`UNO_NUM_VALUES)) begin
                color_cnt[add_color][add_value] <= color_cnt[add_color][add_value] + 1'b1;
            end
        end else if (hand.remove_valid) begin
            hand_num_r <= hand_num_r - 1'b1;
            score_r    <= score_r - card_score(rem_value);
            if (rem_value == value_t'(`UNO_WILD)) begin
                wild_cnt <= wild_cnt - 1'b1;
            end else if (rem_value == value_t'(`UNO_WILD4)) begin
                wild4_cnt <= wild4_cnt - 1'b1;
            end else if (rem_value < value_t'(`UNO_NUM_VALUES)) begin
                color_cnt[rem_color][rem_value] <= color_cnt[rem_color][rem_value] - 1'b1;
            end
        end
    end

    // summaries straight from the counts, no extra cycle
    always_comb begin
        color_present = '0;
        value_colors  = '0;
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
                if (color_cnt[c][v] != '0) begin
                    color_present[c] = 1'b1;
                    if (hand.query_value == value_t'(v)) begin
                        value_colors[c] = 1'b1;
                    end
                end
            end
        end
    end

    assign hand.color_present = color_present;
    assign hand.value_colors  = value_colors;   // zero for queries above 12
    assign hand.wild_present  = (wild_cnt != '0);
    assign hand.wild4_present = (wild4_cnt != '0);

    assign o_hand_num = hand_num_r;
    assign o_score    = score_r;

endmodule

`default_nettype wire

// ==== hw/turn_fsm.sv ====
`default_nettype none

`include "uno_macros.svh"

module turn_fsm
    import uno_card_pkg::*;
    import uno_player_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    input  wire logic  i_init,
    input  wire logic  i_start,
    input  wire logic  i_draw_two,
    input  wire logic  i_draw_four,
    input  wire logic  i_drawn,
    input  wire logic  i_check,
    input  wire card_t i_prev_card,
    input  wire card_t i_drawn_card,
    output card_t      o_out_card,
    output logic       o_out,
    output logic       o_draw_card,
    hand_if.player     hand
);

    player_state_t state_r, state_w;
    draw_iter_t    iter_r, iter_w;
    card_t         out_card_r, out_card_w;
    logic [3:0]    lfsr_r;
    logic [3:0]    lfsr_w;

    color_t        prev_color;
    value_t        prev_value;
    logic          prev_wild;
    value_t        pick_value;
    color_mask_t   prev_mask;
    color_mask_t   other_held;
    color_mask_t   wild_colors;

    logic          add_valid;
    logic          remove_valid;
    card_t         remove_card;

    // lowest set colour, red first
    function automatic color_t first_color(input color_mask_t m);
        color_t c;
        c = '0;
        for (int i = 3; i >= 0; i--) begin
            if (m[i]) begin
                c = color_t'(i);
            end
        end
        return c;
    endfunction

    assign {prev_color, prev_value} = i_prev_card;
    assign prev_wild = (prev_value == value_t'(`UNO_WILD)) ||
                       (prev_value == value_t'(`UNO_WILD4));

    assign lfsr_w     = {lfsr_r[0] ^ lfsr_r[1], lfsr_r[3:1]};
    assign pick_value = lfsr_r - 1'b1;   // lfsr never hits 0, so this spans 0 to 14

    // a wild goes to a held colour other than the previous one,
    // or to any other colour when no such colour is held
    assign prev_mask   = color_mask_t'(1) << prev_color;
    assign other_held  = hand.color_present & ~prev_mask;
    assign wild_colors = (other_held != '0) ? other_held : ~prev_mask;

    always_comb begin
        state_w      = state_r;
        iter_w       = iter_r;
        out_card_w   = out_card_r;
        add_valid    = 1'b0;
        remove_valid = 1'b0;
        remove_card  = '0;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    if (i_draw_two) begin
                        state_w = S_DRAW;
                        iter_w  = draw_iter_t'(2);
                    end else if (i_draw_four) begin
                        state_w = S_DRAW;
                        iter_w  = draw_iter_t'(4);
                    end else begin
                        state_w = S_CHECK_COLOR;
                    end
                end else if (i_init) begin
                    state_w = S_DRAW;
                    iter_w  = draw_iter_t'(`UNO_DEAL_SIZE);
                end
            end
            S_DRAW: begin
                if (i_drawn) begin
                    add_valid = 1'b1;
                    iter_w    = iter_r - 1'b1;
                    if (iter_r <= draw_iter_t'(1)) begin
                        state_w = i_start ? S_CHECK_COLOR : S_IDLE;   // play on after a penalty
                    end
                end
            end
            S_CHECK_COLOR: begin
                // query_value carries the random pick in this state
                if (prev_wild || !hand.color_present[prev_color]) begin
                    state_w = S_CHECK_NUM;
                end else if (hand.value_colors[prev_color]) begin
                    remove_valid = 1'b1;
                    remove_card  = {prev_color, pick_value};
                    out_card_w   = {prev_color, pick_value};
                    state_w      = S_OUT;
                end
            end
            S_CHECK_NUM: begin
                if (!prev_wild && hand.value_colors != '0) begin
                    remove_valid = 1'b1;
                    remove_card  = {first_color(hand.value_colors), prev_value};
                    out_card_w   = {first_color(hand.value_colors), prev_value};
                    state_w      = S_OUT;
                end else if (hand.wild_present) begin
                    out_card_w = {prev_color, value_t'(`UNO_WILD)};
                    state_w    = S_CHOOSE;
                end else if (hand.wild4_present) begin
                    out_card_w = {prev_color, value_t'(`UNO_WILD4)};
                    state_w    = S_CHOOSE;
                end else begin
                    state_w = S_NOCARD;
                end
            end
            S_CHOOSE: begin
                if (wild_colors[lfsr_r[1:0]]) begin
                    remove_valid = 1'b1;
                    remove_card  = out_card_r;
                    out_card_w   = {lfsr_r[1:0], out_card_r[3:0]};
                    state_w      = S_OUT;
                end
            end
            S_NOCARD: begin
                if (i_drawn) begin
                    add_valid = 1'b1;
                    state_w   = S_IDLE;
                end
            end
            S_OUT: begin
                if (i_check) begin
                    out_card_w = '0;
                    state_w    = S_IDLE;
                end
            end
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r    <= S_IDLE;
            iter_r     <= '0;
            out_card_r <= '0;
            lfsr_r     <= `UNO_LFSR_SEED;
        end else begin
            state_r    <= state_w;
            iter_r     <= iter_w;
            out_card_r <= out_card_w;
            lfsr_r     <= lfsr_w;   // free running
        end
    end

    assign hand.add_valid    = add_valid;
    assign hand.add_card     = i_drawn_card;
    assign hand.remove_valid = remove_valid;
    assign hand.remove_card  = remove_card;
    assign hand.query_value  = (state_r == S_CHECK_COLOR) ? pick_value : prev_value;

    assign o_out_card  = out_card_r;
    assign o_out       = (state_r == S_OUT);
    assign o_draw_card = (state_r == S_NOCARD);

endmodule

`default_nettype wire

// ==== hw/uno_card_pkg.sv ====
`default_nettype none

`include "uno_macros.svh"

package uno_card_pkg;

    typedef logic [`UNO_CARD_W-1:0] card_t;

    // colour order: red, yellow, green, blue
    typedef logic [1:0] color_t;
    typedef logic [3:0] value_t;

    // one bit per colour, indexed by color_t
    typedef logic [3:0] color_mask_t;

    typedef logic [1:0]  count_t;     // copies of one card
    typedef logic [6:0]  hand_num_t;
    typedef logic [10:0] score_t;

endpackage

`default_nettype wire

// ==== hw/uno_computer.sv ====
`default_nettype none

module uno_computer
    import uno_card_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    input  wire logic  i_init,
    input  wire logic  i_start,
    input  wire card_t i_prev_card,
    output card_t      o_out_card,
    output logic       o_draw_card,
    input  wire logic  i_draw_two,
    input  wire logic  i_draw_four,
    input  wire logic  i_drawn,
    input  wire logic  i_check,
    input  wire card_t i_drawn_card,
    output logic       o_out,
    output hand_num_t  o_hand_num,
    output score_t     o_score
);

    hand_if u_hand_if ();

    hand_store u_hand_store (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .hand       (u_hand_if.store),
        .o_hand_num (o_hand_num),
        .o_score    (o_score)
    );

    turn_fsm u_turn_fsm (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init       (i_init),
        .i_start      (i_start),
        .i_draw_two   (i_draw_two),
        .i_draw_four  (i_draw_four),
        .i_drawn      (i_drawn),
        .i_check      (i_check),
        .i_prev_card  (i_prev_card),
        .i_drawn_card (i_drawn_card),
        .o_out_card   (o_out_card),
        .o_out        (o_out),
        .o_draw_card  (o_draw_card),
        .hand         (u_hand_if.player)
    );

endmodule

`default_nettype wire

// ==== hw/uno_macros.svh ====
`ifndef UNO_MACROS_SVH
`define UNO_MACROS_SVH

// card layout is {colour[1:0], value[3:0]}
`define UNO_CARD_W 6

// coloured values run 0 to 12 in each colour
`define UNO_NUM_VALUES 13

// wild value codes
`define UNO_WILD  13
`define UNO_WILD4 14

// penalty points
`define UNO_ACTION_SCORE 20   // values 10 to 12
`define UNO_WILD_SCORE   50   // both wild kinds

// cards taken on i_init
`define UNO_DEAL_SIZE 7

// any non-zero value works, the sequence has period 15
`define UNO_LFSR_SEED 4'b0110

`endif

// ==== hw/uno_player_pkg.sv ====
`default_nettype none

package uno_player_pkg;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DRAW,         // penalty or deal draws
        S_CHECK_COLOR,
        S_CHECK_NUM,
        S_CHOOSE,       // colour pick for a wild
        S_NOCARD,
        S_OUT
    } player_state_t;

    typedef logic [2:0] draw_iter_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/bash
# build and run the testbench, then search the log for the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_uno_computer \
    -Mdir obj_dir -o sim_uno > build.log 2>&1 \
    && ./obj_dir/sim_uno > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }

! grep -q "Finished with errors" sim.log && grep -q "Finished with no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== sources.f ====
+incdir+hw
hw/uno_card_pkg.sv
hw/uno_player_pkg.sv
hw/hand_if.sv
hw/hand_store.sv
hw/turn_fsm.sv
hw/uno_computer.sv
verification/tb_uno_computer.sv

// ==== verification/tb_uno_computer.sv ====
`default_nettype none

`include "uno_macros.svh"

module tb_uno_computer
    import uno_card_pkg::*;
();

    localparam int TIMEOUT     = 64;
    localparam int DRIVE_DLY   = 2;
    localparam int HOLD_CYCLES = 3;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_init;
    logic        i_start;
    logic        i_draw_two;
    logic        i_draw_four;
    logic        i_drawn;
    logic        i_check;
    card_t       i_prev_card;
    card_t       i_drawn_card;
    card_t       o_out_card;
    logic        o_out;
    logic        o_draw_card;
    hand_num_t   o_hand_num;
    score_t      o_score;

    int          held [4][16];    // wilds are kept under colour 0
    int          model_num;
    int          model_score;
    int          errors;
    int          errors_at_start;
    int          tests;
    int          failed_tests;
    logic [31:0] lfsr;

    uno_computer u_uno_computer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init       (i_init),
        .i_start      (i_start),
        .i_prev_card  (i_prev_card),
        .o_out_card   (o_out_card),
        .o_draw_card  (o_draw_card),
        .i_draw_two   (i_draw_two),
        .i_draw_four  (i_draw_four),
        .i_drawn      (i_drawn),
        .i_check      (i_check),
        .i_drawn_card (i_drawn_card),
        .o_out        (o_out),
        .o_hand_num   (o_hand_num),
        .o_score      (o_score)
    );

    always #20 i_clk = ~i_clk;

    // a card request holds until i_drawn
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_draw_card && !i_drawn |=> o_draw_card)
        else note_error("o_draw_card dropped before i_drawn");

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_out && !i_check |=> o_out && $stable(o_out_card))
        else note_error("shown card changed or dropped before i_check");

    // taps 32 22 2 1 with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic card_t random_card();
        color_t c;
        value_t v;
        c = color_t'(rand_bits(2));
        v = value_t'(rand_bits(4) % 15);    // no code 15
        return {c, v};
    endfunction

    function automatic int score_of(input value_t v);
        if (v >= value_t'(`UNO_WILD)) return `UNO_WILD_SCORE;
        if (v >= value_t'(10)) return `UNO_ACTION_SCORE;
        return int'(v);
    endfunction

    function automatic int held_count(input card_t c);
        if (c[3:0] >= value_t'(`UNO_WILD)) return held[0][c[3:0]];
        return held[c[5:4]][c[3:0]];
    endfunction

    function automatic logic color_held(input color_t c);
        logic h;
        h = 1'b0;
        for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
            if (held[c][v] != 0) h = 1'b1;
        end
        return h;
    endfunction

    function automatic logic value_held(input value_t v);
        logic h;
        h = 1'b0;
        for (int c = 0; c < 4; c++) begin
            if (v < value_t'(`UNO_NUM_VALUES) && held[c][v] != 0) h = 1'b1;
        end
        return h;
    endfunction

    task automatic update_model(input card_t c, input int delta);
        if (c[3:0] >= value_t'(`UNO_WILD)) held[0][c[3:0]] += delta;
        else held[c[5:4]][c[3:0]] += delta;
        model_num   += delta;
        model_score += delta * score_of(c[3:0]);
    endtask

    task automatic note_error(input string what);
        errors++;
        $display("ERROR %s", what);
    endtask

    task automatic expect_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic step();
        @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    task automatic check_counts();
        expect_eq("o_hand_num", int'(o_hand_num), model_num);
        expect_eq("o_score", int'(o_score), model_score);
    endtask

    // one i_drawn pulse and a quiet cycle after it
    task automatic draw_card(input card_t c);
        i_drawn      = 1'b1;
        i_drawn_card = c;
        step();
        i_drawn = 1'b0;
        update_model(c, 1);
        check_counts();
        step();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors > errors_at_start) begin
            failed_tests++;
            $display("test %s failed", name);
        end else begin
            $display("test %s passed", name);
        end
        errors_at_start = errors;
    endtask

    task automatic play_turn(input card_t prev, input int penalty);
        color_t pc;
        value_t pv;
        color_t gc;
        value_t gv;
        card_t  got;
        logic   pw;
        logic   others;
        logic   exp_draw;
        int     n;
        i_prev_card = prev;
        i_start     = 1'b1;
        i_draw_two  = (penalty == 2);
        i_draw_four = (penalty == 4);
        step();
        i_draw_two  = 1'b0;
        i_draw_four = 1'b0;
        for (int k = 0; k < penalty; k++) draw_card(random_card());
        pc = prev[5:4];
        pv = prev[3:0];
        pw = (pv >= value_t'(`UNO_WILD));
        others = 1'b0;
        for (int c = 0; c < 4; c++) begin
            if (color_t'(c) != pc && color_held(color_t'(c))) others = 1'b1;
        end
        exp_draw = (pw || (!color_held(pc) && !value_held(pv))) &&
                   held[0][`UNO_WILD] == 0 && held[0][`UNO_WILD4] == 0;
        n = 0;
        while (!o_out && !o_draw_card && n < TIMEOUT) begin
            step();
            n++;
        end
        i_start = 1'b0;
        repeat (HOLD_CYCLES) step();    // keep the player waiting on its response
        if (!o_out && !o_draw_card) begin
            note_error("timeout waiting for o_out or o_draw_card");
        end else if (o_draw_card) begin
            assert (exp_draw) else note_error("asked for a card while holding a playable one");
            draw_card(random_card());
            expect_eq("o_draw_card", int'(o_draw_card), 0);
        end else begin
            assert (!exp_draw) else note_error("played a card with nothing playable");
            got = o_out_card;
            gc  = got[5:4];
            gv  = got[3:0];
            assert (held_count(got) > 0) else note_error("played card is not in the hand");
            if (!pw && color_held(pc)) begin
                assert (gc == pc && gv < value_t'(`UNO_NUM_VALUES))
                    else note_error("card of the previous colour expected");
            end else if (!pw && value_held(pv)) begin
                assert (gv == pv) else note_error("card of the previous value expected");
            end else begin
                assert (gv >= value_t'(`UNO_WILD) && gc != pc && (!others || color_held(gc)))
                    else note_error("wild card or its new colour is wrong");
            end
            update_model(got, -1);
            check_counts();
            i_check = 1'b1;
            step();
            i_check = 1'b0;
            expect_eq("o_out", int'(o_out), 0);
            expect_eq("o_out_card", int'(o_out_card), 0);
        end
    endtask

    initial begin
        lfsr         = 32'h0374fd12;
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_init       = 1'b0;
        i_start      = 1'b0;
        i_draw_two   = 1'b0;
        i_draw_four  = 1'b0;
        i_drawn      = 1'b0;
        i_check      = 1'b0;
        i_prev_card  = '0;
        i_drawn_card = '0;
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < 16; v++) held[c][v] = 0;
        end
        model_num       = 0;
        model_score     = 0;
        errors          = 0;
        errors_at_start = 0;
        tests           = 0;
        failed_tests    = 0;
        repeat (10) @(posedge i_clk);
        #DRIVE_DLY i_rst_n = 1'b1;
        step();
        expect_eq("o_out", int'(o_out), 0);
        expect_eq("o_draw_card", int'(o_draw_card), 0);
        expect_eq("o_out_card", int'(o_out_card), 0);
        check_counts();
        repeat (4) begin
            step();
            assert (!o_out && !o_draw_card) else note_error("output active while idle");
        end
        end_test("reset");

        i_init = 1'b1;
        step();
        i_init = 1'b0;
        draw_card({2'd0, 4'd3});
        draw_card({2'd0, 4'd11});
        draw_card({2'd1, 4'd5});
        draw_card({2'd2, 4'd5});
        draw_card({2'd2, 4'd8});
        draw_card({2'd0, 4'd13});
        draw_card({2'd0, 4'd14});
        expect_eq("o_hand_num", int'(o_hand_num), `UNO_DEAL_SIZE);
        end_test("initial deal");

        play_turn({2'd0, 4'd9}, 0);     // red held
        end_test("colour match");
        play_turn({2'd3, 4'd5}, 0);     // no blue but fives held
        end_test("value match");
        play_turn({2'd3, 4'd2}, 0);
        end_test("wild play");
        play_turn({2'd1, 4'd13}, 0);    // only a wild answers a wild
        end_test("wild on wild");
        play_turn({2'd3, 4'd2}, 0);
        end_test("no playable card");
        play_turn({2'd0, 4'd7}, 2);
        end_test("draw two");

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
